/* common/tlb_pkg.sv */
// Address translation shared types
`default_nettype none

package tlb_pkg;

  // Address and page geometry
  localparam int unsigned SlvAddrWidth    = 32;
  localparam int unsigned MstAddrWidth    = 40;
  localparam int unsigned PageOffsetWidth = 12;
  localparam int unsigned SlvPageWidth    = SlvAddrWidth - PageOffsetWidth;
  localparam int unsigned MstPageWidth    = MstAddrWidth - PageOffsetWidth;

  localparam int unsigned IdWidth      = 4;
  localparam int unsigned CfgDataWidth = 32;
  localparam int unsigned RespWidth    = 2;

  // Word 0 first page, word 1 last page, word 2 base page, word 3 valid in bit 0
  localparam int unsigned CfgRegsPerEntry = 4;

  typedef logic [SlvAddrWidth-1:0] slv_addr_t;
  typedef logic [MstAddrWidth-1:0] mst_addr_t;
  typedef logic [SlvPageWidth-1:0] slv_page_t;
  typedef logic [MstPageWidth-1:0] mst_page_t;
  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [CfgDataWidth-1:0] cfg_data_t;
  typedef logic [RespWidth-1:0]    resp_t;

  localparam resp_t RespSlvErr = 2'b10;

  // Request before translation
  typedef struct packed {
    id_t       id;
    slv_addr_t addr;
    logic      write;
  } slv_ax_t;

  // Request after translation
  typedef struct packed {
    id_t       id;
    mst_addr_t addr;
    logic      write;
  } mst_ax_t;

  // One page range and its target
  typedef struct packed {
    logic      valid;
    slv_page_t first_page;
    slv_page_t last_page;
    mst_page_t base_page;
  } tlb_entry_t;

  typedef struct packed {
    logic      hit;
    mst_addr_t addr;
  } tlb_res_t;

  typedef struct packed {
    id_t   id;
    logic  write;
    resp_t resp;
  } err_rsp_t;

endpackage

`default_nettype wire

/* verilog/tlb/tlb_entry_regs.sv */
// Translation entry register file
`default_nettype none

module tlb_entry_regs #(
  parameter int unsigned NumEntries = 4,
  localparam int unsigned IdxWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1,
  localparam int unsigned WordWidth = $clog2(tlb_pkg::CfgRegsPerEntry),
  localparam int unsigned CfgAddrWidth = IdxWidth + WordWidth
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  input  wire logic                                 cfg_we_i,
  input  wire logic [CfgAddrWidth-1:0]              cfg_addr_i,
  input  tlb_pkg::cfg_data_t                        cfg_wdata_i,
  output tlb_pkg::cfg_data_t                        cfg_rdata_o,
  output tlb_pkg::tlb_entry_t [NumEntries-1:0]      entries_o
);

  tlb_pkg::tlb_entry_t [NumEntries-1:0] entries_q;
  logic [IdxWidth-1:0]                  entry_idx;
  logic [WordWidth-1:0]                 word_sel;
  logic                                 in_range;

  // Upper bits pick the entry, lower bits the word within it
  assign entry_idx = cfg_addr_i[CfgAddrWidth-1:WordWidth];
  assign word_sel  = cfg_addr_i[WordWidth-1:0];
  assign in_range  = (entry_idx < NumEntries);

  // Entries come out of reset invalid and all zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      entries_q <= '0;
    end else if (cfg_we_i && in_range) begin
      case (word_sel)
        0: entries_q[entry_idx].first_page <= cfg_wdata_i[tlb_pkg::SlvPageWidth-1:0];
        1: entries_q[entry_idx].last_page  <= cfg_wdata_i[tlb_pkg::SlvPageWidth-1:0];
        2: entries_q[entry_idx].base_page  <= cfg_wdata_i[tlb_pkg::MstPageWidth-1:0];
        default: entries_q[entry_idx].valid <= cfg_wdata_i[0];
      endcase
    end
  end

  // Fields read back zero-extended to the data width
  always_comb begin
    cfg_rdata_o = '0;
    if (in_range) begin
      case (word_sel)
        0: cfg_rdata_o = tlb_pkg::cfg_data_t'(entries_q[entry_idx].first_page);
        1: cfg_rdata_o = tlb_pkg::cfg_data_t'(entries_q[entry_idx].last_page);
        2: cfg_rdata_o = tlb_pkg::cfg_data_t'(entries_q[entry_idx].base_page);
        default: cfg_rdata_o = tlb_pkg::cfg_data_t'(entries_q[entry_idx].valid);
      endcase
    end
  end

  assign entries_o = entries_q;

  // Config master must stay inside the implemented table
  cfg_addr_in_table: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_we_i |-> (cfg_addr_i < NumEntries * tlb_pkg::CfgRegsPerEntry)
  ) else $error("config write outside table, addr %0d", cfg_addr_i);

endmodule

`default_nettype wire

/* verilog/tlb/tlb_lookup.sv */
// Page range lookup and translation
`default_nettype none

module tlb_lookup #(
  parameter int unsigned NumEntries = 4,
  localparam int unsigned IdxWidth = (NumEntries > 1) ? $clog2(NumEntries) : 1
) (
  input  tlb_pkg::slv_addr_t                   addr_i,
  input  tlb_pkg::tlb_entry_t [NumEntries-1:0] entries_i,
  output tlb_pkg::tlb_res_t                    res_o
);

  tlb_pkg::slv_page_t    page;
  logic [NumEntries-1:0] match;
  logic                  hit;
  logic [IdxWidth-1:0]   hit_idx;
  tlb_pkg::slv_page_t    page_delta;
  tlb_pkg::mst_page_t    mst_page;

  assign page = addr_i[tlb_pkg::SlvAddrWidth-1:tlb_pkg::PageOffsetWidth];

  // All ranges compared in parallel
  for (genvar i = 0; i < NumEntries; i++) begin : gen_match
    assign match[i] = entries_i[i].valid &&
                      (page >= entries_i[i].first_page) &&
                      (page <= entries_i[i].last_page);
  end

  // Walk down so the lowest matching index is the last one written
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_idx = IdxWidth'(i);
      end
    end
  end

  // Offset into the range rebased onto the wider master page
  assign page_delta = page - entries_i[hit_idx].first_page;
  assign mst_page   = entries_i[hit_idx].base_page + tlb_pkg::mst_page_t'(page_delta);

  assign res_o.hit  = hit;
  assign res_o.addr = hit ? {mst_page, addr_i[tlb_pkg::PageOffsetWidth-1:0]} : '0;

endmodule

`default_nettype wire

/* verilog/axi_tlb_ctrl.sv */
// Translation control stage
`default_nettype none

module axi_tlb_ctrl (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  // Slave side request
  input  tlb_pkg::slv_ax_t   slv_ax_i,
  input  wire logic          slv_valid_i,
  output logic               slv_ready_o,
  // Lookup result for the current slave request
  input  tlb_pkg::tlb_res_t  res_i,
  // Master side for hits
  output tlb_pkg::mst_ax_t   mst_ax_o,
  output logic               mst_valid_o,
  input  wire logic          mst_ready_i,
  // Miss path toward the error responder
  output tlb_pkg::err_rsp_t  miss_rsp_o,
  output logic               miss_valid_o,
  input  wire logic          miss_ready_i
);

  typedef enum logic {
    EMPTY,
    FULL
  } state_e;

  state_e              state_q;
  state_e              state_d;
  tlb_pkg::mst_ax_t    ax_q;
  logic                hit_q;
  logic                slv_fire;
  logic                out_fire;

  // Hit bit picks the one output that carries the held item
  assign mst_valid_o  = (state_q == FULL) && hit_q;
  assign miss_valid_o = (state_q == FULL) && !hit_q;

  assign out_fire = (mst_valid_o && mst_ready_i) || (miss_valid_o && miss_ready_i);

  // Take a new request when empty or while the held one leaves
  assign slv_ready_o = (state_q == EMPTY) || out_fire;
  assign slv_fire    = slv_valid_i && slv_ready_o;

  always_comb begin
    state_d = state_q;
    if (slv_fire) begin
      state_d = FULL;
    end else if (out_fire) begin
      state_d = EMPTY;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // Request is held with its translated address so later table writes leave it alone
  always_ff @(posedge clk_i) begin
    if (slv_fire) begin
      ax_q.id    <= slv_ax_i.id;
      ax_q.addr  <= res_i.addr;
      ax_q.write <= slv_ax_i.write;
      hit_q      <= res_i.hit;
    end
  end

  assign mst_ax_o = ax_q;

  // Response code is filled in by the error responder
  assign miss_rsp_o.id    = ax_q.id;
  assign miss_rsp_o.write = ax_q.write;
  assign miss_rsp_o.resp  = '0;

  mst_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (mst_valid_o && !mst_ready_i) |=> (mst_valid_o && $stable(mst_ax_o))
  ) else $error("master request changed under back-pressure");

  miss_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (miss_valid_o && !miss_ready_i) |=> (miss_valid_o && $stable(miss_rsp_o))
  ) else $error("miss request changed under back-pressure");

endmodule

`default_nettype wire

/* verilog/tlb_err_resp.sv */
// Slave error response FIFO
`default_nettype none

module tlb_err_resp #(
  parameter int unsigned ErrFifoDepth = 2,
  localparam int unsigned PtrWidth = (ErrFifoDepth > 1) ? $clog2(ErrFifoDepth) : 1,
  localparam int unsigned CntWidth = $clog2(ErrFifoDepth + 1)
) (
  input  wire logic          clk_i,
  input  wire logic          rst_n_i,
  input  tlb_pkg::err_rsp_t  miss_rsp_i,
  input  wire logic          miss_valid_i,
  output logic               miss_ready_o,
  output tlb_pkg::err_rsp_t  err_rsp_o,
  output logic               err_valid_o,
  input  wire logic          err_ready_i
);

  tlb_pkg::err_rsp_t    mem_q [ErrFifoDepth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 push;
  logic                 pop;

  assign miss_ready_o = (count_q != CntWidth'(ErrFifoDepth));
  assign err_valid_o  = (count_q != '0);
  assign push = miss_valid_i && miss_ready_o;
  assign pop  = err_valid_o && err_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(ErrFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(ErrFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Every absorbed miss answers with SLVERR
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q].id    <= miss_rsp_i.id;
      mem_q[wr_ptr_q].write <= miss_rsp_i.write;
      mem_q[wr_ptr_q].resp  <= tlb_pkg::RespSlvErr;
    end
  end

  assign err_rsp_o = mem_q[rd_ptr_q];

  // A push while full or a pop while empty drives the count out of range
  no_overflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntWidth'(ErrFifoDepth)
  ) else $error("error FIFO count beyond its depth");

  // Pointers meet exactly when the FIFO is empty or full
  no_underflow: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (rd_ptr_q == wr_ptr_q) == ((count_q == '0) || (count_q == CntWidth'(ErrFifoDepth)))
  ) else $error("error FIFO pointers disagree with its count");

endmodule

`default_nettype wire

/* verilog/axi_tlb.sv */
// Address translation unit top
`default_nettype none

module axi_tlb #(
  parameter int unsigned NumEntries = 4,
  parameter int unsigned ErrFifoDepth = 2,
  localparam int unsigned CfgAddrWidth = ((NumEntries > 1) ? $clog2(NumEntries) : 1) +
                                         $clog2(tlb_pkg::CfgRegsPerEntry)
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // Slave request
  input  tlb_pkg::slv_ax_t              slv_ax_i,
  input  wire logic                     slv_valid_i,
  output logic                          slv_ready_o,
  // Master request
  output tlb_pkg::mst_ax_t              mst_ax_o,
  output logic                          mst_valid_o,
  input  wire logic                     mst_ready_i,
  // Error response
  output tlb_pkg::err_rsp_t             err_rsp_o,
  output logic                          err_valid_o,
  input  wire logic                     err_ready_i,
  // Configuration
  input  wire logic                     cfg_we_i,
  input  wire logic [CfgAddrWidth-1:0]  cfg_addr_i,
  input  tlb_pkg::cfg_data_t            cfg_wdata_i,
  output tlb_pkg::cfg_data_t            cfg_rdata_o
);

  tlb_pkg::tlb_entry_t [NumEntries-1:0] entries;
  tlb_pkg::tlb_res_t                    lookup_res;
  tlb_pkg::err_rsp_t                    miss_rsp;
  logic                                 miss_valid;
  logic                                 miss_ready;

  tlb_entry_regs #(
    .NumEntries  ( NumEntries )
  ) i_entry_regs (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .entries_o   ( entries     )
  );

  // Lookup runs on the request as it is offered
  tlb_lookup #(
    .NumEntries  ( NumEntries )
  ) i_lookup (
    .addr_i      ( slv_ax_i.addr ),
    .entries_i   ( entries       ),
    .res_o       ( lookup_res    )
  );

  axi_tlb_ctrl i_ctrl (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .slv_ax_i     ( slv_ax_i    ),
    .slv_valid_i  ( slv_valid_i ),
    .slv_ready_o  ( slv_ready_o ),
    .res_i        ( lookup_res  ),
    .mst_ax_o     ( mst_ax_o    ),
    .mst_valid_o  ( mst_valid_o ),
    .mst_ready_i  ( mst_ready_i ),
    .miss_rsp_o   ( miss_rsp    ),
    .miss_valid_o ( miss_valid  ),
    .miss_ready_i ( miss_ready  )
  );

  tlb_err_resp #(
    .ErrFifoDepth ( ErrFifoDepth )
  ) i_err_resp (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .miss_rsp_i   ( miss_rsp    ),
    .miss_valid_i ( miss_valid  ),
    .miss_ready_o ( miss_ready  ),
    .err_rsp_o    ( err_rsp_o   ),
    .err_valid_o  ( err_valid_o ),
    .err_ready_i  ( err_ready_i )
  );

endmodule

`default_nettype wire

/* dv/tb_axi_tlb.sv */
// Address translation unit testbench
`default_nettype none

module tb_axi_tlb;

  localparam int unsigned NumEntries   = 4;
  localparam int unsigned ErrFifoDepth = 2;
  localparam int unsigned CfgAddrWidth = $clog2(NumEntries) + $clog2(tlb_pkg::CfgRegsPerEntry);
  localparam int unsigned Timeout      = 200;
  localparam logic [31:0] Seed         = 32'hb29b_5cdc;

  logic                     clk;
  logic                     rst_n;
  tlb_pkg::slv_ax_t         slv_ax;
  logic                     slv_valid;
  logic                     slv_ready;
  tlb_pkg::mst_ax_t         mst_ax;
  logic                     mst_valid;
  logic                     mst_ready;
  tlb_pkg::err_rsp_t        err_rsp;
  logic                     err_valid;
  logic                     err_ready;
  logic                     cfg_we;
  logic [CfgAddrWidth-1:0]  cfg_addr;
  tlb_pkg::cfg_data_t       cfg_wdata;
  tlb_pkg::cfg_data_t       cfg_rdata;

  // Reference copy of the programmed table
  tlb_pkg::slv_page_t model_first [NumEntries];
  tlb_pkg::slv_page_t model_last  [NumEntries];
  tlb_pkg::mst_page_t model_base  [NumEntries];
  logic               model_valid [NumEntries];

  tlb_pkg::mst_ax_t   exp_mst [$];
  tlb_pkg::err_rsp_t  exp_err [$];
  logic [31:0]        rnd;
  logic [31:0]        stall_rnd;
  logic               stall_en;
  logic               hit_due;
  int                 value_errors;
  int                 other_errors;
  string              test_name;

  axi_tlb #(
    .NumEntries   ( NumEntries   ),
    .ErrFifoDepth ( ErrFifoDepth )
  ) axi_tlb_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .slv_ax_i    ( slv_ax    ),
    .slv_valid_i ( slv_valid ),
    .slv_ready_o ( slv_ready ),
    .mst_ax_o    ( mst_ax    ),
    .mst_valid_o ( mst_valid ),
    .mst_ready_i ( mst_ready ),
    .err_rsp_o   ( err_rsp   ),
    .err_valid_o ( err_valid ),
    .err_ready_i ( err_ready ),
    .cfg_we_i    ( cfg_we    ),
    .cfg_addr_i  ( cfg_addr  ),
    .cfg_wdata_i ( cfg_wdata ),
    .cfg_rdata_o ( cfg_rdata )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd = xorshift(rnd);
    return rnd;
  endfunction

  // First matching entry in index order gives the translation
  function automatic tlb_pkg::tlb_res_t translate(input tlb_pkg::slv_addr_t addr);
    tlb_pkg::tlb_res_t  res;
    tlb_pkg::slv_page_t page;
    res  = '0;
    page = tlb_pkg::slv_page_t'(addr >> tlb_pkg::PageOffsetWidth);
    for (int i = 0; i < NumEntries; i++) begin
      if (!res.hit && model_valid[i] && page >= model_first[i] && page <= model_last[i]) begin
        res.hit  = 1'b1;
        res.addr = {model_base[i] + tlb_pkg::mst_page_t'(page - model_first[i]),
                    addr[tlb_pkg::PageOffsetWidth-1:0]};
      end
    end
    return res;
  endfunction

  // Random page inside the entry's range with a random offset
  function automatic tlb_pkg::slv_addr_t hit_addr(input int e);
    logic [31:0]        r;
    tlb_pkg::slv_page_t span;
    r    = next_rand();
    span = model_last[e] - model_first[e] + 1'b1;
    return {model_first[e] + (r[31:12] % span), r[11:0]};
  endfunction

  // Pages 0xc0000 and up are never programmed
  function automatic tlb_pkg::slv_addr_t miss_addr();
    tlb_pkg::slv_addr_t addr;
    addr        = next_rand();
    addr[31:28] = 4'hc;
    return addr;
  endfunction

  task automatic report_mismatch(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
    value_errors++;
    $display("Fail %s: %s expected %h actual %h", test_name, what, expected, actual);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic cfg_write(input int idx, input int word, input tlb_pkg::cfg_data_t data);
    tlb_pkg::cfg_data_t expected;
    @(posedge clk);
    #1;
    cfg_we    = 1'b1;
    cfg_addr  = CfgAddrWidth'(idx * tlb_pkg::CfgRegsPerEntry + word);
    cfg_wdata = data;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    case (word)
      0: begin
        expected = data & 32'h000f_ffff;
        model_first[idx] = expected[19:0];
      end
      1: begin
        expected = data & 32'h000f_ffff;
        model_last[idx] = expected[19:0];
      end
      2: begin
        expected = data & 32'h0fff_ffff;
        model_base[idx] = expected[27:0];
      end
      default: begin
        expected = {31'b0, data[0]};
        model_valid[idx] = data[0];
      end
    endcase
    assert (cfg_rdata == expected) else report_mismatch("read-back", expected, cfg_rdata);
  endtask

  // Upper bits of each word carry junk that the register file drops
  task automatic program_entry(input int idx, input tlb_pkg::slv_page_t first,
                               input tlb_pkg::slv_page_t last, input tlb_pkg::mst_page_t base);
    cfg_write(idx, 0, {next_rand() & 32'hfff0_0000} | first);
    cfg_write(idx, 1, {next_rand() & 32'hfff0_0000} | last);
    cfg_write(idx, 2, {next_rand() & 32'hf000_0000} | base);
    cfg_write(idx, 3, 32'hffff_fff1);
  endtask

  task automatic send_req(input tlb_pkg::slv_addr_t addr);
    logic [31:0] r;
    logic        accepted;
    int          waited;
    r            = next_rand();
    slv_ax.id    = r[3:0];
    slv_ax.addr  = addr;
    slv_ax.write = r[8];
    slv_valid    = 1'b1;
    waited       = 0;
    do begin
      @(posedge clk);
      accepted = slv_ready;
      waited++;
    end while (!accepted && waited < Timeout);
    assert (accepted) else report_problem("slave request was never accepted");
    #1;
    slv_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while ((exp_mst.size() != 0 || exp_err.size() != 0) && waited < Timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (exp_mst.size() == 0 && exp_err.size() == 0 && !mst_valid && !err_valid)
      else report_problem("outstanding requests never completed");
  endtask

  // Ready stalls driven just after the edge
  always @(posedge clk) begin
    #1;
    if (stall_en) begin
      stall_rnd = xorshift(stall_rnd);
      mst_ready = stall_rnd[5];
      err_ready = stall_rnd[17];
    end else begin
      mst_ready = 1'b1;
      err_ready = 1'b1;
    end
  end

  // Outputs are checked against the queues and new requests predicted
  always @(posedge clk) begin
    tlb_pkg::tlb_res_t res;
    if (rst_n) begin
      if (hit_due) begin
        assert (mst_valid) else report_problem("master request missing one cycle after a hit");
      end
      hit_due = 1'b0;
      if (mst_valid && mst_ready) begin
        assert (exp_mst.size() != 0) else report_problem("master request with none expected");
        if (exp_mst.size() != 0) begin
          assert (mst_ax == exp_mst[0]) else report_mismatch("master request", exp_mst[0], mst_ax);
          void'(exp_mst.pop_front());
        end
      end
      if (err_valid && err_ready) begin
        assert (exp_err.size() != 0) else report_problem("error response with none expected");
        if (exp_err.size() != 0) begin
          assert (err_rsp == exp_err[0]) else report_mismatch("error response", exp_err[0], err_rsp);
          void'(exp_err.pop_front());
        end
      end
      if (slv_valid && slv_ready) begin
        res = translate(slv_ax.addr);
        if (res.hit) begin
          exp_mst.push_back(tlb_pkg::mst_ax_t'({slv_ax.id, res.addr, slv_ax.write}));
          hit_due = 1'b1;
        end else begin
          exp_err.push_back(tlb_pkg::err_rsp_t'({slv_ax.id, slv_ax.write, tlb_pkg::RespSlvErr}));
        end
      end
    end
  end

  mst_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (mst_valid && !mst_ready) |=> (mst_valid && $stable(mst_ax))
  ) else report_problem("master request dropped or changed while stalled");

  err_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (err_valid && !err_ready) |=> (err_valid && $stable(err_rsp))
  ) else report_problem("error response dropped or changed while stalled");

  initial begin
    rst_n        = 1'b0;
    slv_ax       = '0;
    slv_valid    = 1'b0;
    mst_ready    = 1'b1;
    err_ready    = 1'b1;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    stall_en     = 1'b0;
    hit_due      = 1'b0;
    value_errors = 0;
    other_errors = 0;
    rnd          = Seed;
    stall_rnd    = xorshift(Seed ^ 32'h5a5a_5a5a);
    for (int i = 0; i < NumEntries; i++) begin
      model_first[i] = '0;
      model_last[i]  = '0;
      model_base[i]  = '0;
      model_valid[i] = 1'b0;
    end

    test_name = "reset";
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    #1;
    assert (!mst_valid && !err_valid && slv_ready) else report_problem("outputs not idle after reset");

    // Entries 0 and 1 overlap on pages 0x180 to 0x1ff
    test_name = "config";
    program_entry(0, 20'h00100, 20'h001ff, 28'h800_0000);
    program_entry(1, 20'h00180, 20'h0027f, 28'h012_3400);
    program_entry(2, 20'h40000, 20'h4000f, 28'hfff_0000);
    program_entry(3, 20'h80000, 20'h80003, 28'h000_0abc);

    test_name = "hit";
    send_req({20'h001c0, 12'h345});
    send_req({20'h001ff, 12'hfff});
    repeat (40) send_req(hit_addr(int'(next_rand() % NumEntries)));
    wait_drained();

    test_name = "miss";
    repeat (20) send_req(miss_addr());
    cfg_write(3, 3, 32'h0000_0000);
    repeat (8) send_req(hit_addr(3));
    wait_drained();

    test_name = "stall";
    stall_en = 1'b1;
    for (int n = 0; n < 80; n++) begin
      if (next_rand() & 32'h1) begin
        send_req(hit_addr(int'(next_rand() % NumEntries)));
      end else begin
        send_req(miss_addr());
      end
    end
    wait_drained();
    stall_en = 1'b0;

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_tlb.f */
common/tlb_pkg.sv
verilog/tlb/tlb_entry_regs.sv
verilog/tlb/tlb_lookup.sv
verilog/axi_tlb_ctrl.sv
verilog/tlb_err_resp.sv
verilog/axi_tlb.sv
dv/tb_axi_tlb.sv

/* Bender.yml */
package:
  name: axi_tlb

dependencies: {}

sources:
  # Shared package
  - common/tlb_pkg.sv
  # Translation table
  - verilog/tlb/tlb_entry_regs.sv
  - verilog/tlb/tlb_lookup.sv
  # Control, error path and top level
  - verilog/axi_tlb_ctrl.sv
  - verilog/tlb_err_resp.sv
  - verilog/axi_tlb.sv
  # Testbench
  - target: test
    files:
      - dv/tb_axi_tlb.sv
